//--- hdl/video_pkg.sv
package video_pkg;

    // chip codes
    // bit 0 set marks a PAL part
    localparam logic [1:0] CHIP_6567R8   = 2'd0;
    localparam logic [1:0] CHIP_6569R5   = 2'd1;
    localparam logic [1:0] CHIP_6567R56A = 2'd2;
    localparam logic [1:0] CHIP_6569R1   = 2'd3;

    // raster units per line
    localparam logic [9:0] NTSC_LINE_LEN = 10'd520;
    localparam logic [9:0] PAL_LINE_LEN  = 10'd504;

    // horizontal sync placement
    localparam logic [9:0] NTSC_HSYNC_START = 10'd8;
    localparam logic [9:0] PAL_HSYNC_START  = 10'd7;
    localparam logic [9:0] HSYNC_LEN        = 10'd37;

    // first visible x after the sync tip and back porch
    localparam logic [9:0] NTSC_HVISIBLE_START = NTSC_HSYNC_START + 10'd88;
    localparam logic [9:0] PAL_HVISIBLE_START  = PAL_HSYNC_START + 10'd84;

    // burst begins five units after sync ends
    localparam logic [9:0] NTSC_BURST_START = NTSC_HSYNC_START + HSYNC_LEN + 10'd5;
    localparam logic [9:0] PAL_BURST_START  = PAL_HSYNC_START + HSYNC_LEN + 10'd5;

    // vertical blanking group of nine lines
    localparam logic [8:0] NTSC_VBLANK_START = 9'd14;
    localparam logic [8:0] PAL_VBLANK_START  = 9'd301;
    localparam logic [8:0] VBLANK_LINES      = 9'd9;

    // equalization pulse width and serration gap
    localparam logic [9:0] EQ_LEN   = 10'd18;
    localparam logic [9:0] SERR_GAP = 10'd37;

    // fixed output levels
    localparam logic [5:0] BLANK_LEVEL     = 6'd18;
    localparam logic [3:0] BURST_AMPLITUDE = 4'd9;
    localparam logic [5:0] CHROMA_ZERO     = 6'd32;

    // nine colour periods of 16 samples
    localparam logic [7:0] BURST_SAMPLES = 8'd144;

    // burst phase offsets in 1/256 of a turn
    localparam logic [7:0] NTSC_BURST_PHASE     = 8'd128;
    localparam logic [7:0] PAL_BURST_PHASE_EVEN = 8'd96;
    localparam logic [7:0] PAL_BURST_PHASE_ODD  = 8'd160;

    localparam int PALETTE_DEPTH = 16;

    // used only when the sine table is built
    localparam real TWO_PI = 6.283185307179586;

    typedef struct packed {
        logic [5:0] luma;
        logic [7:0] phase;
        logic [3:0] amplitude;
    } palette_fields_t;

    // one palette word, seen as the bus value or as its fields
    typedef union packed {
        logic [17:0]     raw;
        palette_fields_t fields;
    } palette_entry_t;

endpackage

//--- hdl/palette_regs.sv
`timescale 1ns/1ps

module palette_regs (
    input  logic        clk_col16x,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  pixel_color,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r,
    output logic [5:0]  pal_luma,
    output logic [7:0]  pal_phase,
    output logic [3:0]  pal_amplitude
);

    // sixteen colour entries
    video_pkg::palette_entry_t entries [video_pkg::PALETTE_DEPTH];

    // new request seen this cycle
    // the ~wb_ack term forces one idle cycle between acks
    logic wb_req;

    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    // bus handshake
    // ack rises one cycle after cyc and stb and lasts one cycle
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req;
        end
    end

    // entry storage
    // a write lands on the edge that raises ack so it is visible during ack
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            for (int i = 0; i < video_pkg::PALETTE_DEPTH; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (wb_req && wb_we)
        begin
            entries[wb_adr].raw <= wb_dat_w[17:0];
        end
    end

    // read data captured with ack, upper bits read as zero
    always_ff @(posedge clk_col16x)
    begin
        if (wb_req)
        begin
            wb_dat_r <= {14'd0, entries[wb_adr].raw};
        end
    end

    // colour lookup for the video path
    // one register stage, aligned with sync_gen
    always_ff @(posedge clk_col16x)
    begin
        pal_luma      <= entries[pixel_color].fields.luma;
        pal_phase     <= entries[pixel_color].fields.phase;
        pal_amplitude <= entries[pixel_color].fields.amplitude;
    end

endmodule

//--- hdl/sync_gen.sv
`timescale 1ns/1ps

module sync_gen (
    input  logic       clk_col16x,
    input  logic [1:0] chip,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_y,
    output logic       hsync,
    output logic       vsync,
    output logic       eq_pulse,
    output logic       serr_pulse,
    output logic [3:0] vblank_line,
    output logic       vblank_valid,
    output logic       active,
    output logic       burst_start
);

    // per-chip constants
    logic [9:0] line_len;
    logic [9:0] hs_start;
    logic [9:0] hv_start;
    logic [9:0] bst_start;
    logic [8:0] vb_start;

    // derived positions
    logic [9:0] half_line;
    logic [9:0] hs_end;
    logic [8:0] vb_end;
    logic [9:0] x_half;
    logic [8:0] y_off;
    logic       vb_hit;

    // chip table
    always_comb
    begin
        case (chip)
            video_pkg::CHIP_6567R8, video_pkg::CHIP_6567R56A:
            begin
                line_len  = video_pkg::NTSC_LINE_LEN;
                hs_start  = video_pkg::NTSC_HSYNC_START;
                hv_start  = video_pkg::NTSC_HVISIBLE_START;
                bst_start = video_pkg::NTSC_BURST_START;
                vb_start  = video_pkg::NTSC_VBLANK_START;
            end
            default:
            begin
                // CHIP_6569R5 and CHIP_6569R1
                line_len  = video_pkg::PAL_LINE_LEN;
                hs_start  = video_pkg::PAL_HSYNC_START;
                hv_start  = video_pkg::PAL_HVISIBLE_START;
                bst_start = video_pkg::PAL_BURST_START;
                vb_start  = video_pkg::PAL_VBLANK_START;
            end
        endcase
    end

    assign half_line = line_len >> 1;
    assign hs_end    = hs_start + video_pkg::HSYNC_LEN;
    assign vb_end    = vb_start + video_pkg::VBLANK_LINES - 9'd1;

    // position within the current half line
    // x never reaches a full line so one subtraction is enough
    assign x_half = (raster_x >= half_line) ? raster_x - half_line : raster_x;

    // vertical blanking group and offset into it
    assign y_off  = raster_y - vb_start;
    assign vb_hit = (raster_y >= vb_start) &&
                    (raster_y < vb_start + video_pkg::VBLANK_LINES);

    // all flags leave on one register stage
    always_ff @(posedge clk_col16x)
    begin
        hsync        <= (raster_x >= hs_start) && (raster_x < hs_end);
        // vsync opens at sync start of the first blank line
        // and closes at sync end of the last one
        vsync        <= ((raster_y == vb_start && raster_x >= hs_start) ||
                         raster_y > vb_start) &&
                        (raster_y < vb_end ||
                         (raster_y == vb_end && raster_x < hs_end));
        eq_pulse     <= x_half < video_pkg::EQ_LEN;
        serr_pulse   <= x_half < half_line - video_pkg::SERR_GAP;
        vblank_valid <= vb_hit;
        vblank_line  <= y_off[3:0];
        active       <= (raster_x >= hv_start) && !vb_hit;
        burst_start  <= raster_x == bst_start;
    end

endmodule

//--- hdl/luma_gen.sv
`timescale 1ns/1ps

module luma_gen (
    input  logic       clk_col16x,
    input  logic       rst,
    input  logic       hsync,
    input  logic       vblank_valid,
    input  logic [3:0] vblank_line,
    input  logic       eq_pulse,
    input  logic       serr_pulse,
    input  logic       active,
    input  logic [5:0] pal_luma,
    output logic [5:0] luma
);

    // selected vertical pulse and the next luma value
    logic       v_pulse;
    logic [5:0] luma_next;

    always_comb
    begin
        // middle three blank lines carry serration
        // the outer six carry equalization
        case (vblank_line)
            4'd3, 4'd4, 4'd5:
                v_pulse = serr_pulse;
            default:
                v_pulse = eq_pulse;
        endcase

        if (vblank_valid)
        begin
            luma_next = v_pulse ? 6'd0 : video_pkg::BLANK_LEVEL;
        end
        else if (hsync)
        begin
            // sync tip
            luma_next = 6'd0;
        end
        else if (active)
        begin
            luma_next = pal_luma;
        end
        else
        begin
            luma_next = video_pkg::BLANK_LEVEL;
        end
    end

    // output register, second stage after the raster inputs
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            luma <= 6'd0;
        end
        else
        begin
            luma <= luma_next;
        end
    end

endmodule

//--- hdl/chroma_gen.sv
`timescale 1ns/1ps

module chroma_gen (
    input  logic        clk_col16x,
    input  logic        rst,
    input  logic [1:0]  chip,
    input  logic [8:0]  raster_y,
    input  logic        vsync,
    input  logic        active,
    input  logic        burst_start,
    input  logic [7:0]  pal_phase,
    input  logic [3:0]  pal_amplitude,
    input  logic [8:0]  rom_data,
    output logic [11:0] rom_addr,
    output logic [5:0]  chroma
);

    // free-running sample index within one colour period
    logic [3:0] phase_cnt;

    // raster line aligned with the sync_gen flags, and the previous one
    logic [8:0] y_d;
    logic [8:0] y_prev;

    // burst sequencing
    logic       armed;
    logic       in_burst;
    logic [7:0] burst_cnt;
    logic       armed_now;
    logic       burst_go;
    logic       burst_on;

    // sine lookup terms
    logic       is_pal;
    logic       odd_line;
    logic [3:0] amp_sel;
    logic [7:0] phase_offset;
    logic [7:0] wave_addr;

    // amplitude that went with the address, one and two stages on
    logic [3:0] amp_q2;
    logic [3:0] amp_q3;

    assign is_pal   = chip[0];
    assign odd_line = y_d[0];

    // a changed line number re-arms the burst
    assign armed_now = armed | (y_d != y_prev);
    assign burst_go  = burst_start & armed_now & ~in_burst;
    assign burst_on  = in_burst | burst_go;

    always_ff @(posedge clk_col16x)
    begin
        y_d <= raster_y;
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            phase_cnt <= 4'd0;
            y_prev    <= 9'd0;
            armed     <= 1'b0;
            in_burst  <= 1'b0;
            burst_cnt <= 8'd0;
        end
        else
        begin
            phase_cnt <= phase_cnt + 4'd1;
            y_prev    <= y_d;
            armed     <= armed_now & ~burst_go;
            // burst_on covers exactly BURST_SAMPLES cycles
            if (burst_on)
            begin
                if (burst_cnt == video_pkg::BURST_SAMPLES - 8'd1)
                begin
                    in_burst  <= 1'b0;
                    burst_cnt <= 8'd0;
                end
                else
                begin
                    in_burst  <= 1'b1;
                    burst_cnt <= burst_cnt + 8'd1;
                end
            end
        end
    end

    always_comb
    begin
        // amplitude priority is vsync, active, burst
        if (vsync)
            amp_sel = 4'd0;
        else if (active)
            amp_sel = pal_amplitude;
        else if (burst_on)
            amp_sel = video_pkg::BURST_AMPLITUDE;
        else
            amp_sel = 4'd0;

        // PAL flips the colour phase on odd lines, 256 minus phase mod 256
        if (active)
            phase_offset = (is_pal && odd_line) ? 8'd0 - pal_phase : pal_phase;
        else if (!is_pal)
            phase_offset = video_pkg::NTSC_BURST_PHASE;
        else
            phase_offset = odd_line ? video_pkg::PAL_BURST_PHASE_ODD
                                    : video_pkg::PAL_BURST_PHASE_EVEN;

        // 16 table steps per colour period, wraps at 256
        wave_addr = {phase_cnt, 4'b0000} + phase_offset;
    end

    // stage 2 carries the rom address
    always_ff @(posedge clk_col16x)
    begin
        rom_addr <= {amp_sel, wave_addr};
    end

    // stages 2 to 4 of the amplitude and the output register
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            amp_q2 <= 4'd0;
            amp_q3 <= 4'd0;
            chroma <= video_pkg::CHROMA_ZERO;
        end
        else
        begin
            amp_q2 <= amp_sel;
            amp_q3 <= amp_q2;
            // zero amplitude gives the flat centre level
            chroma <= (amp_q3 == 4'd0) ? video_pkg::CHROMA_ZERO : rom_data[8:3];
        end
    end

endmodule

//--- hdl/sine_rom.sv
`timescale 1ns/1ps

module sine_rom (
    input  logic        clk_col16x,
    input  logic [11:0] rom_addr,
    output logic [8:0]  rom_data
);

    // 16 amplitudes of 256 samples each
    // upper address nibble picks the amplitude
    logic [8:0] table_mem [0:4095];

    // table built once at elaboration
    initial
    begin
        int  amp;
        int  idx;
        real angle;
        real scaled;
        for (int a = 0; a < 4096; a++)
        begin
            amp    = a / 256;
            idx    = a % 256;
            angle  = video_pkg::TWO_PI * idx / 256.0;
            scaled = amp * 16.0 * $sin(angle);
            // wave centred on 256, product truncated toward zero
            table_mem[a] = 9'(256 + $rtoi(scaled));
        end
    end

    // registered read
    always_ff @(posedge clk_col16x)
    begin
        rom_data <= table_mem[rom_addr];
    end

endmodule

//--- hdl/video_encoder_top.sv
`timescale 1ns/1ps

module video_encoder_top (
    input  logic        clk_col16x,
    input  logic        rst,
    input  logic [1:0]  chip,
    input  logic [9:0]  raster_x,
    input  logic [8:0]  raster_y,
    input  logic [3:0]  pixel_color,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r,
    output logic [5:0]  luma,
    output logic [5:0]  chroma
);

    // palette lookup, one cycle after pixel_color
    logic [5:0]  pal_luma;
    logic [7:0]  pal_phase;
    logic [3:0]  pal_amplitude;

    // sync flags, one cycle after the raster position
    logic        hsync;
    logic        vsync;
    logic        eq_pulse;
    logic        serr_pulse;
    logic [3:0]  vblank_line;
    logic        vblank_valid;
    logic        active;
    logic        burst_start;

    // sine table port
    logic [11:0] rom_addr;
    logic [8:0]  rom_data;

    palette_regs u_palette (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .pixel_color   (pixel_color),
        .wb_ack        (wb_ack),
        .wb_dat_r      (wb_dat_r),
        .pal_luma      (pal_luma),
        .pal_phase     (pal_phase),
        .pal_amplitude (pal_amplitude)
    );

    sync_gen u_sync (
        .clk_col16x   (clk_col16x),
        .chip         (chip),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .hsync        (hsync),
        .vsync        (vsync),
        .eq_pulse     (eq_pulse),
        .serr_pulse   (serr_pulse),
        .vblank_line  (vblank_line),
        .vblank_valid (vblank_valid),
        .active       (active),
        .burst_start  (burst_start)
    );

    luma_gen u_luma (
        .clk_col16x   (clk_col16x),
        .rst          (rst),
        .hsync        (hsync),
        .vblank_valid (vblank_valid),
        .vblank_line  (vblank_line),
        .eq_pulse     (eq_pulse),
        .serr_pulse   (serr_pulse),
        .active       (active),
        .pal_luma     (pal_luma),
        .luma         (luma)
    );

    chroma_gen u_chroma (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .chip          (chip),
        .raster_y      (raster_y),
        .vsync         (vsync),
        .active        (active),
        .burst_start   (burst_start),
        .pal_phase     (pal_phase),
        .pal_amplitude (pal_amplitude),
        .rom_data      (rom_data),
        .rom_addr      (rom_addr),
        .chroma        (chroma)
    );

    sine_rom u_sine (
        .clk_col16x (clk_col16x),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data)
    );

endmodule

//--- bench/video_encoder_assertions.sv
`timescale 1ns/1ps

module video_encoder_assertions (
    input logic       clk_col16x,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       hsync,
    input logic       vsync,
    input logic       vblank_valid,
    input logic [5:0] luma,
    input logic [5:0] chroma
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // ack only inside a bus cycle
    ack_in_cycle: assert property (@(posedge clk_col16x) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb)
    else
    begin
        fail_count++;
        $error("wishbone ack without cyc and stb");
    end

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk_col16x) disable iff (rst)
        wb_ack |=> !wb_ack)
    else
    begin
        fail_count++;
        $error("wishbone ack held for two cycles");
    end

    // sync tip one stage after the hsync flag
    hsync_tip: assert property (@(posedge clk_col16x) disable iff (rst)
        hsync && !vblank_valid |=> luma == 6'd0)
    else
    begin
        fail_count++;
        $error("luma not at sync tip after hsync");
    end

    // no colour during vertical sync, three stages after the flag
    vsync_flat: assert property (@(posedge clk_col16x) disable iff (rst)
        vsync |-> ##3 chroma == video_pkg::CHROMA_ZERO)
    else
    begin
        fail_count++;
        $error("chroma not flat during vsync");
    end

endmodule

bind video_encoder_top video_encoder_assertions u_checks (
    .clk_col16x   (clk_col16x),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .hsync        (hsync),
    .vsync        (vsync),
    .vblank_valid (vblank_valid),
    .luma         (luma),
    .chroma       (chroma)
);

//--- bench/video_encoder_tb.sv
`timescale 1ns/1ps

module video_encoder_tb;

    localparam int CLK_PERIOD = 10;
    // both chip runs take about 15 000 cycles, budget 40 000 with a 5x margin
    localparam int TEST_CYCLES   = 40000;
    localparam int WATCHDOG_TIME = TEST_CYCLES * CLK_PERIOD * 5;
    localparam real TWO_PI = 6.283185307179586;

    logic        clk_col16x;
    logic        rst;
    logic [1:0]  chip;
    logic [9:0]  raster_x;
    logic [8:0]  raster_y;
    logic [3:0]  pixel_color;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic [5:0]  luma;
    logic [5:0]  chroma;

    int seed = 72;
    // cycles since rst fell, mirrors the chroma phase counter
    int ticks = 0;
    video_pkg::palette_entry_t pal_model [16];

    // timing of the selected chip
    int line_len;
    int hs_x;
    int hv_x;
    int bst_x;
    int vb_y;

    // burst model state
    int   last_y;
    logic armed;
    int   burst_left;
    int   burst_seen;

    // expected results of the last four samples, index 0 is the newest
    logic [5:0] luma_hist [4];
    logic [5:0] chroma_hist [4];
    logic       hist_valid [4];
    logic       chroma_valid [4];

    video_encoder_top uut (
        .clk_col16x  (clk_col16x),
        .rst         (rst),
        .chip        (chip),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .pixel_color (pixel_color),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .luma        (luma),
        .chroma      (chroma)
    );

    always #(CLK_PERIOD / 2) clk_col16x = ~clk_col16x;

    always @(posedge clk_col16x)
    begin
        if (rst)
            ticks <= 0;
        else
            ticks <= ticks + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // sync, blanking and palette rules for one sample
    function automatic logic [5:0] luma_model(input int x, input int y, input int c);
        int   half;
        int   xh;
        int   off;
        logic pulse;
        half = line_len / 2;
        xh   = (x >= half) ? x - half : x;
        if (y >= vb_y && y < vb_y + video_pkg::VBLANK_LINES)
        begin
            off = y - vb_y;
            // serration on the middle three lines, equalization elsewhere
            if (off >= 3 && off <= 5)
                pulse = xh < half - video_pkg::SERR_GAP;
            else
                pulse = xh < video_pkg::EQ_LEN;
            return pulse ? 6'd0 : video_pkg::BLANK_LEVEL;
        end
        if (x >= hs_x && x < hs_x + video_pkg::HSYNC_LEN)
            return 6'd0;
        if (x >= hv_x)
            return pal_model[c].fields.luma;
        return video_pkg::BLANK_LEVEL;
    endfunction

    // top six bits of the sine sample, product truncated toward zero
    function automatic logic [5:0] sine_level(input int amp, input int idx);
        real angle;
        real scaled;
        int  level;
        angle  = TWO_PI * idx / 256.0;
        scaled = amp * 16.0 * $sin(angle);
        level  = 256 + $rtoi(scaled);
        return level[8:3];
    endfunction

    function automatic logic [5:0] chroma_model(input int x, input int y, input int c,
                                                input int ph, input logic in_b);
        int amp;
        int offset;
        amp    = 0;
        offset = 0;
        if (x >= hv_x)
        begin
            amp    = pal_model[c].fields.amplitude;
            offset = pal_model[c].fields.phase;
            // PAL inverts the colour phase on odd lines
            if (chip[0] && (y % 2) == 1)
                offset = (256 - offset) % 256;
        end
        else if (in_b)
        begin
            amp = video_pkg::BURST_AMPLITUDE;
            if (!chip[0])
                offset = video_pkg::NTSC_BURST_PHASE;
            else
                offset = ((y % 2) == 1) ? video_pkg::PAL_BURST_PHASE_ODD
                                        : video_pkg::PAL_BURST_PHASE_EVEN;
        end
        if (amp == 0)
            return video_pkg::CHROMA_ZERO;
        return sine_level(amp, (ph * 16 + offset) % 256);
    endfunction

    // one clock: check the samples that come out, then drive the next one
    task automatic advance(input int x, input int y, input int c);
        logic in_b;
        logic in_vb;
        int   i;
        @(negedge clk_col16x);
        // cycles in which the chroma path carries the burst
        if (uut.u_chroma.burst_on)
            burst_seen++;
        // luma is two edges behind its inputs
        if (hist_valid[1])
        begin
            assert (luma === luma_hist[1])
            else
                report_failure($sformatf("Error at %0t: luma %0d, expected %0d",
                                         $time, luma, luma_hist[1]));
        end
        // chroma is four edges behind
        if (hist_valid[3] && chroma_valid[3])
        begin
            assert (chroma === chroma_hist[3])
            else
                report_failure($sformatf("Error at %0t: chroma %0d, expected %0d",
                                         $time, chroma, chroma_hist[3]));
        end
        raster_x    = 10'(x);
        raster_y    = 9'(y);
        pixel_color = 4'(c);
        // a new line re-arms the burst, which then runs for 144 samples
        if (y != last_y)
            armed = 1'b1;
        if (burst_left > 0)
        begin
            in_b = 1'b1;
            burst_left--;
        end
        else if (x == bst_x && armed)
        begin
            in_b       = 1'b1;
            burst_left = video_pkg::BURST_SAMPLES - 1;
            armed      = 1'b0;
        end
        else
        begin
            in_b = 1'b0;
        end
        last_y = y;
        in_vb  = (y >= vb_y) && (y < vb_y + video_pkg::VBLANK_LINES);
        for (i = 3; i > 0; i--)
        begin
            luma_hist[i]    = luma_hist[i - 1];
            chroma_hist[i]  = chroma_hist[i - 1];
            hist_valid[i]   = hist_valid[i - 1];
            chroma_valid[i] = chroma_valid[i - 1];
        end
        // phase counter steps once more before the address is formed
        luma_hist[0]    = luma_model(x, y, c);
        chroma_hist[0]  = chroma_model(x, y, c, (ticks + 1) % 16, in_b);
        hist_valid[0]   = 1'b1;
        chroma_valid[0] = !in_vb;
    endtask

    task automatic apply_reset(input logic [1:0] c);
        int i;
        @(negedge clk_col16x);
        rst    = 1'b1;
        chip   = c;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        raster_x    = '0;
        raster_y    = '0;
        pixel_color = '0;
        line_len = c[0] ? video_pkg::PAL_LINE_LEN : video_pkg::NTSC_LINE_LEN;
        hs_x     = c[0] ? video_pkg::PAL_HSYNC_START : video_pkg::NTSC_HSYNC_START;
        hv_x     = c[0] ? video_pkg::PAL_HVISIBLE_START : video_pkg::NTSC_HVISIBLE_START;
        bst_x    = c[0] ? video_pkg::PAL_BURST_START : video_pkg::NTSC_BURST_START;
        vb_y     = c[0] ? video_pkg::PAL_VBLANK_START : video_pkg::NTSC_VBLANK_START;
        repeat (2) @(posedge clk_col16x);
        @(negedge clk_col16x);
        assert (luma === 6'd0 && chroma === 6'd32 && wb_ack === 1'b0)
        else
            report_failure($sformatf("Error at %0t: outputs not idle in reset", $time));
        rst        = 1'b0;
        last_y     = 0;
        armed      = 1'b0;
        burst_left = 0;
        for (i = 0; i < 16; i++)
            pal_model[i] = '0;
        for (i = 0; i < 4; i++)
            hist_valid[i] = 1'b0;
    endtask

    // single classic cycle, stb held one cycle past ack to see it drop
    task automatic wb_access(input logic we, input int adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        assert (wb_ack === 1'b0)
        else
            report_failure($sformatf("Error at %0t: ack high before request", $time));
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = 4'(adr);
        wb_dat_w = data;
        advance(0, 0, 0);
        assert (wb_ack === 1'b1)
        else
            report_failure($sformatf("Error at %0t: no ack one cycle after stb", $time));
        rdata = wb_dat_r;
        advance(0, 0, 0);
        assert (wb_ack === 1'b0)
        else
            report_failure($sformatf("Error at %0t: ack longer than one cycle", $time));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        advance(0, 0, 0);
    endtask

    task automatic palette_access_test();
        video_pkg::palette_entry_t e;
        logic [31:0] data;
        logic [31:0] rd;
        for (int i = 0; i < 16; i++)
        begin
            // upper bits carry noise that must read back as zero
            data  = $random(seed);
            e.raw = data[17:0];
            wb_access(1'b1, i, data, rd);
            pal_model[i] = e;
        end
        for (int i = 0; i < 16; i++)
        begin
            wb_access(1'b0, i, $random(seed), rd);
            assert (rd === {14'd0, pal_model[i].raw})
            else
                report_failure($sformatf("Error at %0t: entry %0d read %h", $time, i, rd));
        end
    endtask

    // amplitude equal to the index, so entry 0 is colourless
    task automatic load_palette();
        video_pkg::palette_entry_t e;
        logic [31:0] data;
        logic [31:0] rd;
        for (int i = 0; i < 16; i++)
        begin
            data               = $random(seed);
            e.fields.luma      = data[5:0];
            e.fields.phase     = data[13:6];
            e.fields.amplitude = 4'(i);
            wb_access(1'b1, i, {14'd0, e.raw}, rd);
            pal_model[i] = e;
        end
    endtask

    task automatic active_luma_test();
        for (int x = 0; x < line_len; x++)
            advance(x, 100, $random(seed) & 15);
    endtask

    task automatic vblank_test();
        for (int line = 0; line < 9; line++)
        begin
            for (int x = 0; x < line_len; x++)
                advance(x, vb_y + line, $random(seed) & 15);
        end
    endtask

    // runs of eight pixels walk through all entries on an odd and an even line
    task automatic active_chroma_test();
        for (int y = 101; y <= 102; y++)
        begin
            for (int x = 0; x < line_len; x++)
                advance(x, y, (x / 8) % 16);
        end
    endtask

    task automatic burst_test();
        for (int y = 51; y <= 52; y++)
        begin
            burst_seen = 0;
            for (int x = 0; x <= bst_x; x++)
                advance(x, y, 0);
            // stay in the blank so the whole burst lands before active video
            repeat (200) advance(bst_x + 10, y, 0);
            assert (burst_seen == video_pkg::BURST_SAMPLES)
            else
                report_failure($sformatf("Error at %0t: %0d burst samples", $time, burst_seen));
            // a second burst_start on the same line must not fire
            advance(bst_x, y, 0);
            repeat (20) advance(bst_x + 10, y, 0);
            assert (burst_seen == video_pkg::BURST_SAMPLES)
            else
                report_failure($sformatf("Error at %0t: burst re-fired on line %0d", $time, y));
        end
    endtask

    initial
    begin
        #(WATCHDOG_TIME);
        report_failure("watchdog expired before the tests finished");
    end

    initial
    begin
        clk_col16x  = 1'b0;
        rst         = 1'b1;
        chip        = video_pkg::CHIP_6567R8;
        raster_x    = '0;
        raster_y    = '0;
        pixel_color = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        for (int run = 0; run < 2; run++)
        begin
            apply_reset(run == 0 ? video_pkg::CHIP_6567R8 : video_pkg::CHIP_6569R5);
            if (run == 0)
                palette_access_test();
            load_palette();
            active_luma_test();
            vblank_test();
            active_chroma_test();
            burst_test();
            // drain the pipeline
            repeat (4) advance(0, 0, 0);
        end
        if (uut.u_checks.fail_count == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            report_failure($sformatf("%0d concurrent assertion failures",
                                     uut.u_checks.fail_count));
        end
    end

endmodule

//--- luma_chroma.f
hdl/video_pkg.sv
hdl/palette_regs.sv
hdl/sync_gen.sv
hdl/luma_gen.sv
hdl/chroma_gen.sv
hdl/sine_rom.sv
hdl/video_encoder_top.sv
bench/video_encoder_assertions.sv
bench/video_encoder_tb.sv
